// File: sensorPkg.sv
`default_nettype none

package sensorPkg;

    // Diode bank switches, big pair and small pair.
    typedef struct packed {
        logic bigPhase1;
        logic bigPhase2;
        logic smallPhase1;
        logic smallPhase2;
    } diodeSw_t;

    // Sampling capacitor switches.
    typedef struct packed {
        logic capA;
        logic capB;
        logic capC;
        logic capD;
    } capSw_t;

    typedef struct packed {
        logic bg2Cmp;   // Bandgap to comparator.
        logic bgCtrl;
        logic ptatCtrl;
        logic cap2Cmp;
        logic ref2Cmp;
        logic capRst;
        logic ptatOut;
        logic rDisconN; // Active low resistor disconnect.
    } biasSw_t;

    // Current trim pulses.
    typedef struct packed {
        logic srcPulse;
        logic snkPulse;
    } trim_t;

endpackage

`default_nettype wire

// File: seqPkg.sv
`default_nettype none

package seqPkg;

    // Top level operating modes.
    typedef enum logic [1:0] {
        PRECHARGE,
        BG_CAL,
        PTAT_MEAS,
        TEMP_SENSE
    } opMode_t;

    // Steps of one diode measurement round.
    typedef enum logic [2:0] {
        IDLE,
        BLANK_BIG,
        BIG_DIODE,
        BLANK_SMALL,
        SMALL_DIODE
    } roundStep_t;

    typedef logic [5:0] cycleCount_t; // Cycle and round counts.

endpackage

`default_nettype wire

// File: modeSupervisor.sv
`timescale 1ns/1ps
`default_nettype none

module modeSupervisor
    import sensorPkg::*;
    import seqPkg::*;
#(
    parameter int PRECHARGE_CYCLES = 16
) (
    input  wire     clk,
    input  wire     reset,
    input  wire     tmpPulse,
    input  wire     bgDone,
    input  wire     ptatDone,
    output opMode_t mode,
    output logic    bgStart,
    output logic    ptatStart,
    output biasSw_t biasSw,
    output capSw_t  prechargeCap,
    output logic    preChrg,
    output logic    setupBias
);

    opMode_t     modeNext;
    cycleCount_t count;
    logic        ptatSeen;

    function automatic biasSw_t biasFor(opMode_t m);
        biasSw_t b;
        b = '0;
        case (m)
            PRECHARGE: begin
                b.bg2Cmp   = 1'b1;
                b.capRst   = 1'b1;
                b.rDisconN = 1'b1;
            end
            BG_CAL: begin
                b.bgCtrl   = 1'b1;
                b.bg2Cmp   = 1'b1;
                b.rDisconN = 1'b1;
            end
            PTAT_MEAS: begin
                b.ptatCtrl = 1'b1; // Resistor stays disconnected.
            end
            default: begin
                b.ptatCtrl = 1'b1;
                b.cap2Cmp  = 1'b1;
                b.ref2Cmp  = 1'b1;
                b.ptatOut  = 1'b1;
            end
        endcase
        return b;
    endfunction

    always_comb begin
        modeNext = mode;
        case (mode)
            PRECHARGE: begin
                if (preChrg && count == cycleCount_t'(PRECHARGE_CYCLES - 1)) begin
                    modeNext = BG_CAL;
                end
            end
            BG_CAL:     if (bgDone) modeNext = PTAT_MEAS;
            PTAT_MEAS:  if (ptatDone) modeNext = TEMP_SENSE;
            default:    if (!tmpPulse) modeNext = BG_CAL; // Back to recalibration.
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode      <= PRECHARGE;
            count     <= '0;
            preChrg   <= 1'b0;
            setupBias <= 1'b0;
            ptatSeen  <= 1'b0;
            bgStart   <= 1'b0;
            ptatStart <= 1'b0;
            biasSw    <= '0;
        end else begin
            mode      <= modeNext;
            biasSw    <= biasFor(modeNext);
            preChrg   <= (modeNext == PRECHARGE);
            count     <= (mode == PRECHARGE && preChrg) ? count + 1'b1 : '0;
            bgStart   <= (modeNext == BG_CAL) && (mode != BG_CAL);
            ptatStart <= (modeNext == PTAT_MEAS) && (mode != PTAT_MEAS);
            ptatSeen  <= ptatSeen || (modeNext == PTAT_MEAS);
            setupBias <= !(ptatSeen || modeNext == PTAT_MEAS);
        end
    end

    // Caps B to D charge while precharge runs.
    assign prechargeCap = preChrg ? capSw_t'(4'b0111) : capSw_t'(4'b0000);

endmodule

`default_nettype wire

// File: diodeRoundSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module diodeRoundSequencer
    import sensorPkg::*;
    import seqPkg::*;
#(
    parameter int BIG_CYCLES   = 6,
    parameter int SMALL_CYCLES = 8
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      roundStart,
    input  wire      cmp,
    output diodeSw_t diodeSw,
    output trim_t    trim,
    output logic     cmpPhase1,
    output logic     cmpPhase2,
    output logic     roundDone,
    output logic     decision
);

    roundStep_t  step;
    cycleCount_t stepCount;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step      <= IDLE;
            stepCount <= '0;
            trim      <= '0;
            cmpPhase1 <= 1'b1;
            roundDone <= 1'b0;
            decision  <= 1'b0;
        end else begin
            trim      <= '0;
            roundDone <= 1'b0;
            case (step)
                IDLE: begin
                    if (roundStart) step <= BLANK_BIG;
                end
                BLANK_BIG: begin
                    step      <= BIG_DIODE;
                    stepCount <= '0;
                end
                BIG_DIODE: begin
                    if (stepCount == cycleCount_t'(BIG_CYCLES - 1)) begin
                        step          <= BLANK_SMALL;
                        decision      <= cmp;
                        trim.srcPulse <= cmp;   // Comparator high sources current.
                        trim.snkPulse <= !cmp;
                        cmpPhase1     <= !cmpPhase1; // Chopper swap per round.
                    end else begin
                        stepCount <= stepCount + 1'b1;
                    end
                end
                BLANK_SMALL: begin
                    step      <= SMALL_DIODE;
                    stepCount <= '0;
                end
                SMALL_DIODE: begin
                    if (stepCount == cycleCount_t'(SMALL_CYCLES - 1)) begin
                        step      <= IDLE;
                        roundDone <= 1'b1;
                    end else begin
                        stepCount <= stepCount + 1'b1;
                    end
                end
                default: step <= IDLE;
            endcase
        end
    end

    assign cmpPhase2 = !cmpPhase1;

    always_comb begin
        diodeSw             = '0;
        diodeSw.bigPhase1   = (step == BIG_DIODE);
        diodeSw.bigPhase2   = (step == BIG_DIODE);
        diodeSw.smallPhase1 = (step == SMALL_DIODE);
        diodeSw.smallPhase2 = (step == SMALL_DIODE);
    end

endmodule

`default_nettype wire

// File: roundArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module roundArbiter
    import sensorPkg::*;
    import seqPkg::*;
(
    input  opMode_t mode,
    input  wire     bgRoundReq,
    input  wire     ptatRoundReq,
    input  wire     roundDone,
    input  wire     decision,
    output logic    roundStart,
    output logic    bgRoundDone,
    output logic    ptatRoundDone,
    output logic    bgDecision,
    input  capSw_t  prechargeCap,
    input  capSw_t  bgCap,
    output capSw_t  capSw
);

    logic bgGrant;
    logic ptatGrant;

    assign bgGrant   = (mode == BG_CAL);
    assign ptatGrant = (mode == PTAT_MEAS);

    // Requests from an engine without the grant are dropped.
    assign roundStart    = (bgGrant && bgRoundReq) || (ptatGrant && ptatRoundReq);
    assign bgRoundDone   = bgGrant && roundDone;
    assign ptatRoundDone = ptatGrant && roundDone;
    assign bgDecision    = bgGrant && decision;

    always_comb begin
        case (mode)
            PRECHARGE: capSw = prechargeCap;
            BG_CAL:    capSw = bgCap;
            default:   capSw = '0; // Caps idle in PTAT and sensing.
        endcase
    end

endmodule

`default_nettype wire

// File: bandgapCalEngine.sv
`timescale 1ns/1ps
`default_nettype none

module bandgapCalEngine
    import sensorPkg::*;
    import seqPkg::*;
#(
    parameter int SETTLE_DECISIONS = 4,
    parameter int OUTPUT_CYCLES    = 16
) (
    input  wire    clk,
    input  wire    reset,
    input  wire    start,
    input  wire    roundDone,
    input  wire    decision,
    output logic   roundReq,
    output capSw_t bgCap,
    output logic   done
);

    logic        running;
    logic        outPhase;
    cycleCount_t count;    // Sink decisions, then output cycles.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running  <= 1'b0;
            outPhase <= 1'b0;
            count    <= '0;
            roundReq <= 1'b0;
            done     <= 1'b0;
        end else begin
            roundReq <= 1'b0;
            done     <= 1'b0;
            if (start) begin
                running  <= 1'b1;
                outPhase <= 1'b0;
                count    <= '0;
                roundReq <= 1'b1;
            end else if (running && roundDone) begin
                if (!decision && count == cycleCount_t'(SETTLE_DECISIONS - 1)) begin
                    running  <= 1'b0;
                    outPhase <= 1'b1;
                    count    <= '0;
                end else begin
                    if (!decision) count <= count + 1'b1;
                    roundReq <= 1'b1;
                end
            end else if (outPhase) begin
                if (count == cycleCount_t'(OUTPUT_CYCLES - 1)) begin
                    outPhase <= 1'b0;
                    done     <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // All caps close to transfer the settled bandgap charge.
    assign bgCap = outPhase ? capSw_t'(4'b1111) : capSw_t'(4'b0000);

endmodule

`default_nettype wire

// File: ptatMeasEngine.sv
`timescale 1ns/1ps
`default_nettype none

module ptatMeasEngine
    import seqPkg::*;
#(
    parameter int PTAT_ROUNDS = 16
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  start,
    input  wire  roundDone,
    output logic roundReq,
    output logic done
);

    logic        running;
    cycleCount_t roundCount;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running    <= 1'b0;
            roundCount <= '0;
            roundReq   <= 1'b0;
            done       <= 1'b0;
        end else begin
            roundReq <= 1'b0;
            done     <= 1'b0;
            if (start) begin
                running    <= 1'b1;
                roundCount <= '0;
                roundReq   <= 1'b1;
            end else if (running && roundDone) begin
                if (roundCount == cycleCount_t'(PTAT_ROUNDS - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1; // Fixed length, no early exit.
                end else begin
                    roundCount <= roundCount + 1'b1;
                    roundReq   <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tempSensorCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tempSensorCtrl
    import sensorPkg::*;
    import seqPkg::*;
#(
    parameter int PRECHARGE_CYCLES = 16,
    parameter int BIG_CYCLES       = 6,
    parameter int SMALL_CYCLES     = 8,
    parameter int SETTLE_DECISIONS = 4,
    parameter int OUTPUT_CYCLES    = 16,
    parameter int PTAT_ROUNDS      = 16
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      cmp,
    input  wire      tmpPulse,
    output diodeSw_t diodeSw,
    output capSw_t   capSw,
    output biasSw_t  biasSw,
    output trim_t    trim,
    output logic     cmpPhase1,
    output logic     cmpPhase2,
    output logic     preChrg,
    output logic     setupBias
);

    opMode_t mode;
    logic    bgStart;
    logic    ptatStart;
    logic    bgDone;
    logic    ptatDone;
    logic    bgRoundReq;
    logic    ptatRoundReq;
    logic    roundStart;
    logic    roundDone;
    logic    decision;
    logic    bgRoundDone;
    logic    ptatRoundDone;
    logic    bgDecision;
    capSw_t  prechargeCap;
    capSw_t  bgCap;

    modeSupervisor #(
        .PRECHARGE_CYCLES(PRECHARGE_CYCLES)
    ) supervisor (
        .clk, .reset, .tmpPulse, .bgDone, .ptatDone, .mode, .bgStart, .ptatStart,
        .biasSw, .prechargeCap, .preChrg, .setupBias
    );

    diodeRoundSequencer #(
        .BIG_CYCLES(BIG_CYCLES),
        .SMALL_CYCLES(SMALL_CYCLES)
    ) sequencer (
        .clk, .reset, .roundStart, .cmp, .diodeSw, .trim, .cmpPhase1, .cmpPhase2,
        .roundDone, .decision
    );

    roundArbiter arbiter (
        .mode, .bgRoundReq, .ptatRoundReq, .roundDone, .decision, .roundStart,
        .bgRoundDone, .ptatRoundDone, .bgDecision, .prechargeCap, .bgCap, .capSw
    );

    bandgapCalEngine #(
        .SETTLE_DECISIONS(SETTLE_DECISIONS),
        .OUTPUT_CYCLES(OUTPUT_CYCLES)
    ) bgEngine (
        .clk, .reset, .start(bgStart), .roundDone(bgRoundDone), .decision(bgDecision),
        .roundReq(bgRoundReq), .bgCap, .done(bgDone)
    );

    ptatMeasEngine #(
        .PTAT_ROUNDS(PTAT_ROUNDS)
    ) ptatEngine (
        .clk, .reset, .start(ptatStart), .roundDone(ptatRoundDone),
        .roundReq(ptatRoundReq), .done(ptatDone)
    );

endmodule

`default_nettype wire

// File: tempSensorCtrl_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tempSensorCtrl_checker
    import sensorPkg::*;
(
    input wire      clk,
    input wire      reset,
    input wire      cmpPhase1,
    input wire      cmpPhase2,
    input trim_t    trim,
    input diodeSw_t diodeSw
);

    logic bigActive;
    logic smallActive;

    assign bigActive   = diodeSw.bigPhase1 || diodeSw.bigPhase2;
    assign smallActive = diodeSw.smallPhase1 || diodeSw.smallPhase2;

    chopperInverse: assert property (@(posedge clk) disable iff (reset) cmpPhase1 != cmpPhase2)
        else $error("cmpPhase1 and cmpPhase2 are not complementary");

    trimExclusive: assert property (@(posedge clk) disable iff (reset)
        !(trim.srcPulse && trim.snkPulse))
        else $error("source and sink trim pulses are high together");

    diodePairsExclusive: assert property (@(posedge clk) disable iff (reset)
        !(bigActive && smallActive))
        else $error("big and small diode pairs are active together");

endmodule

bind tempSensorCtrl tempSensorCtrl_checker protocolChecks (
    .clk(clk), .reset(reset), .cmpPhase1(cmpPhase1), .cmpPhase2(cmpPhase2),
    .trim(trim), .diodeSw(diodeSw)
);

`default_nettype wire

// File: tb_tempSensorCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tempSensorCtrl
    import sensorPkg::*;
();

    localparam int PRECHARGE_CYCLES = 16;
    localparam int BIG_CYCLES       = 6;
    localparam int SMALL_CYCLES     = 8;
    localparam int SETTLE_DECISIONS = 4;
    localparam int OUTPUT_CYCLES    = 16;
    localparam int PTAT_ROUNDS      = 16;
    localparam int ROUND_CYCLES     = BIG_CYCLES + SMALL_CYCLES + 2;

    localparam capSw_t  PRECHARGE_CAPS = '{capA: 1'b0, default: 1'b1};
    localparam capSw_t  ALL_CAPS       = '{default: 1'b1};
    localparam biasSw_t BG_WORD   = '{bgCtrl: 1'b1, bg2Cmp: 1'b1, rDisconN: 1'b1, default: 1'b0};
    localparam biasSw_t PTAT_WORD = '{ptatCtrl: 1'b1, default: 1'b0};
    localparam biasSw_t TEMP_WORD = '{ptatCtrl: 1'b1, cap2Cmp: 1'b1, ref2Cmp: 1'b1,
                                      ptatOut: 1'b1, default: 1'b0};
    localparam diodeSw_t BIG_PAIR = '{bigPhase1: 1'b1, bigPhase2: 1'b1, default: 1'b0};

    logic     clk;
    logic     reset;
    logic     cmp;
    logic     tmpPulse;
    diodeSw_t diodeSw;
    capSw_t   capSw;
    biasSw_t  biasSw;
    trim_t    trim;
    logic     cmpPhase1;
    logic     cmpPhase2;
    logic     preChrg;
    logic     setupBias;

    logic        randomCmp;
    logic [31:0] rngState;
    logic        lastCmp;       // Level the sequencer sampled for the current pulse.
    logic        lastPhase;
    logic        lastPulseSink;
    int          srcCount;
    int          snkCount;
    int          toggleCount;
    int          bigCount;

    tempSensorCtrl #(
        .PRECHARGE_CYCLES(PRECHARGE_CYCLES), .BIG_CYCLES(BIG_CYCLES),
        .SMALL_CYCLES(SMALL_CYCLES), .SETTLE_DECISIONS(SETTLE_DECISIONS),
        .OUTPUT_CYCLES(OUTPUT_CYCLES), .PTAT_ROUNDS(PTAT_ROUNDS)
    ) DUT (
        .clk, .reset, .cmp, .tmpPulse, .diodeSw, .capSw, .biasSw, .trim,
        .cmpPhase1, .cmpPhase2, .preChrg, .setupBias
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Comparator high sources current, low sinks it.
    function automatic trim_t expectedTrim(logic cmpDriven);
        trim_t t;
        t.srcPulse = cmpDriven;
        t.snkPulse = !cmpDriven;
        return t;
    endfunction

    task automatic failRun(string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkValue(string name, int expected, int actual);
        if (expected != actual) begin
            failRun($sformatf("error: %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    task automatic nextSample();
        @(negedge clk);
        #1;
    endtask

    task automatic waitForBias(biasSw_t want, int limit, string what);
        int waited;
        waited = 0;
        while (biasSw != want) begin
            nextSample();
            waited++;
            if (waited > limit) failRun($sformatf("timeout while waiting for %s", what));
        end
    endtask

    task automatic waitForCap(capSw_t want, int limit, string what);
        int waited;
        waited = 0;
        while (capSw != want) begin
            nextSample();
            waited++;
            if (waited > limit) failRun($sformatf("timeout while waiting for %s", what));
        end
    endtask

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (randomCmp) begin
            rngState = xorshift(rngState);
            cmp = rngState[0];
        end else begin
            cmp = 1'b0;
        end
    end

    // Pulse checker, sampled mid-cycle.
    always @(negedge clk) begin
        if (!reset) begin
            if (cmpPhase1 != lastPhase) toggleCount++;
            if (diodeSw == BIG_PAIR) bigCount++;
            if (trim != '0) begin
                checkValue("trim pulse", expectedTrim(lastCmp), trim);
                checkValue("chopper toggles per round", 1, toggleCount);
                checkValue("big diode cycles per round", BIG_CYCLES, bigCount);
                toggleCount = 0;
                bigCount = 0;
                srcCount += trim.srcPulse;
                snkCount += trim.snkPulse;
                lastPulseSink = trim.snkPulse;
            end
            lastPhase = cmpPhase1;
        end
        lastCmp = cmp;
    end

    initial begin
        int waited;
        clk = 1'b0;
        reset = 1'b1;
        cmp = 1'b0;
        tmpPulse = 1'b1;
        randomCmp = 1'b0;
        rngState = 32'd84833;
        lastCmp = 1'b0;
        lastPhase = 1'b1;
        lastPulseSink = 1'b0;
        srcCount = 0;
        snkCount = 0;
        toggleCount = 0;
        bigCount = 0;
        repeat (3) @(posedge clk);
        nextSample();
        checkValue("reset outputs", 0, {diodeSw, capSw, biasSw, trim, preChrg});
        checkValue("reset chopper", 2'b10, {cmpPhase1, cmpPhase2});
        @(posedge clk);
        #1;
        reset = 1'b0;

        waited = 0;
        while (!preChrg) begin
            nextSample();
            waited++;
            if (waited > 4) failRun("timeout while waiting for precharge to start");
        end
        waited = 0;
        while (preChrg) begin
            checkValue("precharge capSw", PRECHARGE_CAPS, capSw);
            checkValue("setupBias during precharge", 1, setupBias);
            waited++;
            if (waited > PRECHARGE_CYCLES + 4) failRun("precharge never ended");
            nextSample();
        end
        checkValue("precharge length", PRECHARGE_CYCLES, waited);

        waitForCap(ALL_CAPS, 20 * ROUND_CYCLES, "bandgap output phase");
        checkValue("bandgap sink pulses", SETTLE_DECISIONS, snkCount);
        checkValue("bandgap source pulses", 0, srcCount);
        waited = 0;
        while (capSw == ALL_CAPS) begin
            checkValue("output phase bgCtrl", 1, biasSw.bgCtrl);
            checkValue("output phase setupBias", 1, setupBias);
            waited++;
            if (waited > OUTPUT_CYCLES + 4) failRun("bandgap output phase never ended");
            nextSample();
        end
        checkValue("output phase length", OUTPUT_CYCLES, waited);

        waitForBias(PTAT_WORD, 8, "PTAT bias word");
        checkValue("setupBias after PTAT entry", 0, setupBias);
        srcCount = 0;
        snkCount = 0;
        waited = 0;
        while (biasSw == PTAT_WORD) begin
            nextSample();
            waited++;
            if (waited > PTAT_ROUNDS * (ROUND_CYCLES + 4)) failRun("PTAT measurement never ended");
        end
        checkValue("PTAT trim pulses", PTAT_ROUNDS, srcCount + snkCount);
        checkValue("bias after PTAT", TEMP_WORD, biasSw);

        srcCount = 0;
        snkCount = 0;
        repeat (3 * ROUND_CYCLES) begin
            checkValue("sensing bias", TEMP_WORD, biasSw);
            nextSample();
        end
        checkValue("trim pulses while sensing", 0, srcCount + snkCount);

        randomCmp = 1'b1;
        @(posedge clk);
        #1;
        tmpPulse = 1'b0;
        waitForBias(BG_WORD, 8, "bandgap bias after tmpPulse fall");
        checkValue("setupBias after recalibration", 0, setupBias);
        waited = 0;
        while (srcCount + snkCount == 0) begin
            nextSample();
            waited++;
            if (waited > 2 * ROUND_CYCLES) failRun("trim pulses did not return after sensing");
        end

        waitForCap(ALL_CAPS, 200 * ROUND_CYCLES, "bandgap output phase with random cmp");
        checkValue("random sink pulses", SETTLE_DECISIONS, snkCount);
        checkValue("settling round ends on a sink", 1, lastPulseSink);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
sensorPkg.sv
seqPkg.sv
modeSupervisor.sv
diodeRoundSequencer.sv
roundArbiter.sv
bandgapCalEngine.sv
ptatMeasEngine.sv
tempSensorCtrl.sv
tempSensorCtrl_checker.sv
tb_tempSensorCtrl.sv

// File: Bender.yml
package:
  name: tempSensorCtrl

sources:
  - sensorPkg.sv
  - seqPkg.sv
  - modeSupervisor.sv
  - diodeRoundSequencer.sv
  - roundArbiter.sv
  - bandgapCalEngine.sv
  - ptatMeasEngine.sv
  - tempSensorCtrl.sv
  - target: simulation
    files:
      - tempSensorCtrl_checker.sv
      - tb_tempSensorCtrl.sv
